/* design/isaPkg.sv */
//----------------------------------------------------------
// Instruction encoding: opcodes, funct3 codes,
// immediate formats and ALU operation codes
//----------------------------------------------------------
package isaPkg;

    // Major opcodes, instruction bits [6:0]
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    // funct3 codes for branches
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    // funct3 codes for register and immediate arithmetic
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Immediate formats for the extend logic in decode
    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrcT;

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOpT;

endpackage

/* design/datapathPkg.sv */
//----------------------------------------------------------
// Datapath widths, select encodings and the packed
// bundles that travel between the pipeline stages
//----------------------------------------------------------
package datapathPkg;

    localparam int xlen        = 32;
    localparam int regAddrBits = 5;

    typedef logic [xlen-1:0]        wordT;
    typedef logic [regAddrBits-1:0] regAddrT;

    // Operand source in execute
    typedef enum logic [1:0] {
        forwardEx  = 2'b00,
        forwardWb  = 2'b01,
        forwardMem = 2'b10
    } forwardSelT;

    // ALU B input source
    typedef enum logic {
        srcBReg = 1'b0,
        srcBImm = 1'b1
    } aluSrcT;

    // Result source in memory and writeback
    typedef enum logic [1:0] {
        resultAlu     = 2'b00,
        resultMem     = 2'b01,
        resultPcPlus4 = 2'b10,
        resultImm     = 2'b11
    } resultSelT;

    typedef struct packed {
        logic stallF;
        logic stallD;
        logic flushD;
        logic flushE;
    } hazardCtrlT;

    typedef struct packed {
        isaPkg::immSrcT immSrc;
        aluSrcT         aluSrc;
        isaPkg::aluOpT  aluControl;
        forwardSelT     forwardA;
        forwardSelT     forwardB;
    } execCtrlT;

    typedef struct packed {
        resultSelT resultSrcM;
        resultSelT resultSrcW;
        logic      regWriteW;
    } resultCtrlT;

    typedef struct packed {
        logic [6:0] op;
        logic [2:0] funct3;
        logic       funct7b5;
        regAddrT    rs1;
        regAddrT    rs2;
        regAddrT    rd;
    } decodeInfoT;

    typedef struct packed {
        regAddrT rs1E;
        regAddrT rs2E;
        regAddrT rdE;
        logic    zeroE;
    } execInfoT;

    typedef struct packed {
        wordT    aluResultM;
        wordT    writeDataM;
        regAddrT rdM;
    } memAccessT;

    typedef struct packed {
        wordT    resultW;
        regAddrT rdW;
        logic    regWriteW;
    } writebackT;

    typedef struct packed {
        wordT    rd1;
        wordT    rd2;
        wordT    pc;
        wordT    pcPlus4;
        wordT    extImm;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
    } decodeToExecT;

    typedef struct packed {
        wordT    aluResult;
        wordT    writeData;
        wordT    pcPlus4;
        wordT    extImm;
        regAddrT rd;
    } execToMemT;

endpackage

/* design/regFile.sv */
//----------------------------------------------------------
// Register file, 32 x 32 bits, two read ports, one write
//----------------------------------------------------------
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  datapathPkg::regAddrT   readAddr1_i,
    input  datapathPkg::regAddrT   readAddr2_i,
    output datapathPkg::wordT      readData1_o,
    output datapathPkg::wordT      readData2_o,
    input  datapathPkg::writebackT writeback_i
);
    import datapathPkg::*;

    // x0 has no storage
    wordT regs [1:31];

    logic writeEn;

    assign writeEn = writeback_i.regWriteW && (writeback_i.rdW != '0);

    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[writeback_i.rdW] <= writeback_i.resultW;
        end
    end

    // Reads see a write to the same register in the same cycle
    always_comb begin
        if (readAddr1_i == '0) begin
            readData1_o = '0;
        end else if (writeEn && (writeback_i.rdW == readAddr1_i)) begin
            readData1_o = writeback_i.resultW;
        end else begin
            readData1_o = regs[readAddr1_i];
        end
    end

    always_comb begin
        if (readAddr2_i == '0) begin
            readData2_o = '0;
        end else if (writeEn && (writeback_i.rdW == readAddr2_i)) begin
            readData2_o = writeback_i.resultW;
        end else begin
            readData2_o = regs[readAddr2_i];
        end
    end

endmodule

/* design/aluUnit.sv */
//----------------------------------------------------------
// Integer ALU with result and zero flag
//----------------------------------------------------------
`timescale 1ns/1ps

module aluUnit (
    input  datapathPkg::wordT srcA_i,
    input  datapathPkg::wordT srcB_i,
    input  isaPkg::aluOpT     aluControl_i,
    output datapathPkg::wordT result_o,
    output logic              zero_o
);
    import isaPkg::*;
    import datapathPkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (aluControl_i)
            aluAdd: begin
                result_o = srcA_i + srcB_i;
            end
            aluSub: begin
                result_o = srcA_i - srcB_i;
            end
            aluAnd: begin
                result_o = srcA_i & srcB_i;
            end
            aluOr: begin
                result_o = srcA_i | srcB_i;
            end
            aluSlt: begin
                result_o = wordT'(lessThan);
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

/* design/fetchDecode.sv */
//----------------------------------------------------------
// Fetch PC with next-PC select, decode register,
// instruction field split and immediate extension
//----------------------------------------------------------
`timescale 1ns/1ps

module fetchDecode #(
    parameter datapathPkg::wordT pcStart = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  datapathPkg::wordT         instrF_i,
    input  logic                      pcSrcE_i,
    input  datapathPkg::wordT         pcTargetE_i,
    input  datapathPkg::hazardCtrlT   hazard_i,
    input  isaPkg::immSrcT            immSrc_i,
    input  datapathPkg::wordT         readData1_i,
    input  datapathPkg::wordT         readData2_i,
    output datapathPkg::wordT         pcF_o,
    output datapathPkg::decodeInfoT   decodeInfo_o,
    output datapathPkg::decodeToExecT decodeToExec_o
);
    import isaPkg::*;
    import datapathPkg::*;

    wordT pcPlus4F;
    wordT pcNextF;
    wordT instrD;
    wordT pcD;
    wordT pcPlus4D;
    wordT extImmD;

    assign pcPlus4F = pcF_o + wordT'(4);
    // Taken branch or jump from execute wins over sequential fetch
    assign pcNextF  = pcSrcE_i ? pcTargetE_i : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= pcStart;
        end else if (!hazard_i.stallF) begin
            pcF_o <= pcNextF;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || hazard_i.flushD) begin
            instrD   <= '0;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else if (!hazard_i.stallD) begin
            instrD   <= instrF_i;
            pcD      <= pcF_o;
            pcPlus4D <= pcPlus4F;
        end
    end

    // Sign-extended immediate in the format chosen by control
    always_comb begin
        case (immSrc_i)
            immI:    extImmD = {{20{instrD[31]}}, instrD[31:20]};
            immS:    extImmD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    extImmD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                instrD[11:8], 1'b0};
            immJ:    extImmD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                instrD[30:21], 1'b0};
            immU:    extImmD = {instrD[31:12], 12'b0};
            default: extImmD = '0;
        endcase
    end

    assign decodeInfo_o.op       = instrD[6:0];
    assign decodeInfo_o.funct3   = instrD[14:12];
    assign decodeInfo_o.funct7b5 = instrD[30];
    assign decodeInfo_o.rs1      = instrD[19:15];
    assign decodeInfo_o.rs2      = instrD[24:20];
    assign decodeInfo_o.rd       = instrD[11:7];

    assign decodeToExec_o.rd1     = readData1_i;
    assign decodeToExec_o.rd2     = readData2_i;
    assign decodeToExec_o.pc      = pcD;
    assign decodeToExec_o.pcPlus4 = pcPlus4D;
    assign decodeToExec_o.extImm  = extImmD;
    assign decodeToExec_o.rs1     = instrD[19:15];
    assign decodeToExec_o.rs2     = instrD[24:20];
    assign decodeToExec_o.rd      = instrD[11:7];

endmodule

/* design/executeStage.sv */
//----------------------------------------------------------
// Execute register, operand forwarding, ALU source select,
// ALU and branch-target adder
//----------------------------------------------------------
`timescale 1ns/1ps

module executeStage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flushE_i,
    input  datapathPkg::execCtrlT     execCtrl_i,
    input  datapathPkg::decodeToExecT decodeToExec_i,
    input  datapathPkg::wordT         forwardMem_i,
    input  datapathPkg::writebackT    writeback_i,
    output datapathPkg::execInfoT     execInfo_o,
    output datapathPkg::wordT         pcTargetE_o,
    output datapathPkg::execToMemT    execToMem_o
);
    import datapathPkg::*;

    decodeToExecT bundleE;
    wordT         srcAE;
    wordT         writeDataE;
    wordT         srcBE;
    wordT         aluResultE;
    logic         zeroE;

    // No stall here, only flush
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            bundleE <= '0;
        end else begin
            bundleE <= decodeToExec_i;
        end
    end

    always_comb begin
        case (execCtrl_i.forwardA)
            forwardMem: srcAE = forwardMem_i;
            forwardWb:  srcAE = writeback_i.resultW;
            forwardEx:  srcAE = bundleE.rd1;
            default:    srcAE = '0;
        endcase
    end

    // Forwarded B value is also the store data
    always_comb begin
        case (execCtrl_i.forwardB)
            forwardMem: writeDataE = forwardMem_i;
            forwardWb:  writeDataE = writeback_i.resultW;
            forwardEx:  writeDataE = bundleE.rd2;
            default:    writeDataE = '0;
        endcase
    end

    assign srcBE = (execCtrl_i.aluSrc == srcBImm) ? bundleE.extImm : writeDataE;

    aluUnit alu (
        .srcA_i       (srcAE),
        .srcB_i       (srcBE),
        .aluControl_i (execCtrl_i.aluControl),
        .result_o     (aluResultE),
        .zero_o       (zeroE)
    );

    // Branch and jal target
    assign pcTargetE_o = bundleE.pc + bundleE.extImm;

    assign execInfo_o.rs1E  = bundleE.rs1;
    assign execInfo_o.rs2E  = bundleE.rs2;
    assign execInfo_o.rdE   = bundleE.rd;
    assign execInfo_o.zeroE = zeroE;

    assign execToMem_o.aluResult = aluResultE;
    assign execToMem_o.writeData = writeDataE;
    assign execToMem_o.pcPlus4   = bundleE.pcPlus4;
    assign execToMem_o.extImm    = bundleE.extImm;
    assign execToMem_o.rd        = bundleE.rd;

endmodule

/* design/resultStage.sv */
//----------------------------------------------------------
// Memory and writeback registers with result selects
//----------------------------------------------------------
`timescale 1ns/1ps

module resultStage (
    input  logic                    clk,
    input  logic                    reset,
    input  datapathPkg::resultCtrlT resultCtrl_i,
    input  datapathPkg::execToMemT  execToMem_i,
    input  datapathPkg::wordT       readDataM_i,
    output datapathPkg::wordT       forwardMem_o,
    output datapathPkg::memAccessT  memAccess_o,
    output datapathPkg::writebackT  writeback_o
);
    import datapathPkg::*;

    execToMemT memM;
    wordT      aluResultW;
    wordT      readDataW;
    wordT      pcPlus4W;
    wordT      extImmW;
    regAddrT   rdW;

    always_ff @(posedge clk) begin
        if (reset) begin
            memM <= '0;
        end else begin
            memM <= execToMem_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultW <= '0;
            readDataW  <= '0;
            pcPlus4W   <= '0;
            extImmW    <= '0;
            rdW        <= '0;
        end else begin
            aluResultW <= memM.aluResult;
            readDataW  <= readDataM_i;
            pcPlus4W   <= memM.pcPlus4;
            extImmW    <= memM.extImm;
            rdW        <= memM.rd;
        end
    end

    // Load data is not back yet, so a load forwards nothing useful
    always_comb begin
        case (resultCtrl_i.resultSrcM)
            resultPcPlus4: forwardMem_o = memM.pcPlus4;
            resultImm:     forwardMem_o = memM.extImm;
            default:       forwardMem_o = memM.aluResult;
        endcase
    end

    always_comb begin
        case (resultCtrl_i.resultSrcW)
            resultMem:     writeback_o.resultW = readDataW;
            resultPcPlus4: writeback_o.resultW = pcPlus4W;
            resultImm:     writeback_o.resultW = extImmW;
            default:       writeback_o.resultW = aluResultW;
        endcase
    end

    assign writeback_o.rdW       = rdW;
    assign writeback_o.regWriteW = resultCtrl_i.regWriteW;

    assign memAccess_o.aluResultM = memM.aluResult;
    assign memAccess_o.writeDataM = memM.writeData;
    assign memAccess_o.rdM        = memM.rd;

endmodule

/* design/pipelineDatapath.sv */
//----------------------------------------------------------
// Five-stage datapath top: stages and register file
//----------------------------------------------------------
`timescale 1ns/1ps

module pipelineDatapath #(
    parameter datapathPkg::wordT pcStart = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  datapathPkg::wordT       instrF_i,
    input  logic                    pcSrcE_i,
    input  datapathPkg::hazardCtrlT hazard_i,
    input  datapathPkg::execCtrlT   execCtrl_i,
    input  datapathPkg::resultCtrlT resultCtrl_i,
    input  datapathPkg::wordT       readDataM_i,
    output datapathPkg::wordT       pcF_o,
    output datapathPkg::decodeInfoT decodeInfo_o,
    output datapathPkg::execInfoT   execInfo_o,
    output datapathPkg::memAccessT  memAccess_o,
    output datapathPkg::writebackT  writeback_o
);
    import datapathPkg::*;

    decodeToExecT decodeToExec;
    execToMemT    execToMem;
    wordT         pcTargetE;
    wordT         forwardMem;
    wordT         readData1;
    wordT         readData2;

    // immSrc belongs to the instruction in decode
    fetchDecode #(
        .pcStart (pcStart)
    ) fetchDecodeInst (
        .clk            (clk),
        .reset          (reset),
        .instrF_i       (instrF_i),
        .pcSrcE_i       (pcSrcE_i),
        .pcTargetE_i    (pcTargetE),
        .hazard_i       (hazard_i),
        .immSrc_i       (execCtrl_i.immSrc),
        .readData1_i    (readData1),
        .readData2_i    (readData2),
        .pcF_o          (pcF_o),
        .decodeInfo_o   (decodeInfo_o),
        .decodeToExec_o (decodeToExec)
    );

    regFile regFileInst (
        .clk         (clk),
        .readAddr1_i (decodeInfo_o.rs1),
        .readAddr2_i (decodeInfo_o.rs2),
        .readData1_o (readData1),
        .readData2_o (readData2),
        .writeback_i (writeback_o)
    );

    executeStage executeInst (
        .clk            (clk),
        .reset          (reset),
        .flushE_i       (hazard_i.flushE),
        .execCtrl_i     (execCtrl_i),
        .decodeToExec_i (decodeToExec),
        .forwardMem_i   (forwardMem),
        .writeback_i    (writeback_o),
        .execInfo_o     (execInfo_o),
        .pcTargetE_o    (pcTargetE),
        .execToMem_o    (execToMem)
    );

    resultStage resultInst (
        .clk          (clk),
        .reset        (reset),
        .resultCtrl_i (resultCtrl_i),
        .execToMem_i  (execToMem),
        .readDataM_i  (readDataM_i),
        .forwardMem_o (forwardMem),
        .memAccess_o  (memAccess_o),
        .writeback_o  (writeback_o)
    );

endmodule

/* verification/datapathTb.sv */
//------------------------------------------------------------
// Testbench for the five-stage datapath: clock, reset,
// instruction encoders, stimulus tasks and checks
//------------------------------------------------------------
`timescale 1ns/1ps

module datapathTb;
    import isaPkg::*;
    import datapathPkg::*;

    localparam wordT startPc    = 32'h0000_1000;
    localparam int   halfPeriod = 4;
    localparam int   waitLimit  = 10;
    localparam int   simLimitNs = 20000;

    logic       clk;
    logic       reset;
    wordT       instrF_i;
    logic       pcSrcE_i;
    hazardCtrlT hazard_i;
    execCtrlT   execCtrl_i;
    resultCtrlT resultCtrl_i;
    wordT       readDataM_i;
    wordT       pcF_o;
    decodeInfoT decodeInfo_o;
    execInfoT   execInfo_o;
    memAccessT  memAccess_o;
    writebackT  writeback_o;
    int         errors = 0;

    pipelineDatapath #(
        .pcStart (startPc)
    ) UUT (
        .clk          (clk),
        .reset        (reset),
        .instrF_i     (instrF_i),
        .pcSrcE_i     (pcSrcE_i),
        .hazard_i     (hazard_i),
        .execCtrl_i   (execCtrl_i),
        .resultCtrl_i (resultCtrl_i),
        .readDataM_i  (readDataM_i),
        .pcF_o        (pcF_o),
        .decodeInfo_o (decodeInfo_o),
        .execInfo_o   (execInfo_o),
        .memAccess_o  (memAccess_o),
        .writeback_o  (writeback_o)
    );

    initial clk = 1'b0;
    always #halfPeriod clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Two reset edges with every input idle
    task automatic applyReset();
        reset        <= 1'b1;
        instrF_i     <= '0;
        pcSrcE_i     <= 1'b0;
        hazard_i     <= '0;
        execCtrl_i   <= '0;
        resultCtrl_i <= '0;
        readDataM_i  <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    function automatic wordT iTypeInstr(input logic [11:0] imm, input regAddrT rs1,
                                        input logic [2:0] funct3, input regAddrT rd);
        return {imm, rs1, funct3, rd, opOpImm};
    endfunction

    // Plain add with funct7 all zero
    function automatic wordT rTypeInstr(input regAddrT rs2, input regAddrT rs1,
                                        input regAddrT rd);
        return {7'b0, rs2, rs1, f3AddSub, rd, opOp};
    endfunction

    function automatic wordT luiInstr(input logic [19:0] upper, input regAddrT rd);
        return {upper, rd, opLui};
    endfunction

    function automatic wordT branchInstr(input logic [12:0] imm, input regAddrT rs2,
                                         input regAddrT rs1);
        return {imm[12], imm[10:5], rs2, rs1, f3Beq, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic decodeInfoT fieldsOf(input wordT instr);
        decodeInfoT info;
        info.op       = instr[6:0];
        info.funct3   = instr[14:12];
        info.funct7b5 = instr[30];
        info.rs1      = instr[19:15];
        info.rs2      = instr[24:20];
        info.rd       = instr[11:7];
        return info;
    endfunction

    // Feed nops into fetch until rd shows up in the memory stage
    task automatic feedNopsUntilMem(input regAddrT rd, input int expEdges, input string name);
        int   edges;
        logic found;
        edges = 0;
        found = 1'b0;
        while (!found && edges < waitLimit) begin
            @(posedge clk);
            instrF_i <= '0;
            edges++;
            @(negedge clk);
            found = (memAccess_o.rdM === rd);
        end
        assert (found) else begin
            errors++;
            $display("Timeout in %s: x%0d never reached the memory stage", name, rd);
        end
        if (found) begin
            checkValue(name, 32'(expEdges), 32'(edges));
        end
    endtask

    task automatic checkAfterReset();
        @(negedge clk);
        checkValue("reset pcF", startPc, pcF_o);
        checkValue("reset aluResultM", '0, memAccess_o.aluResultM);
        checkValue("reset writeDataM", '0, memAccess_o.writeDataM);
        checkValue("reset rdM", '0, 32'(memAccess_o.rdM));
        checkValue("reset resultW", '0, writeback_o.resultW);
        checkValue("reset rdW", '0, 32'(writeback_o.rdW));
        checkValue("reset regWriteW", '0, 32'(writeback_o.regWriteW));
    endtask

    task automatic fetchAndStall();
        wordT expPc;
        logic stallNow;
        int   i;
        expPc    = startPc;
        stallNow = 1'b0;
        for (i = 0; i < 12; i++) begin
            @(posedge clk);
            if (!stallNow) begin
                expPc = expPc + 32'd4;
            end
            // One stall forced early and the rest random
            stallNow = (i == 1) ? 1'b1 : 1'($urandom_range(0, 1));
            hazard_i.stallF <= stallNow;
            @(negedge clk);
            checkValue("fetch pc", expPc, pcF_o);
        end
    endtask

    task automatic decodeFields();
        wordT       instr;
        logic       doFlush;
        hazardCtrlT hazard;
        decodeInfoT expected;
        int         i;
        for (i = 0; i < 8; i++) begin
            instr         = $urandom();
            doFlush       = (i % 3 == 2);
            hazard        = '0;
            hazard.flushD = doFlush;
            @(posedge clk);
            instrF_i <= instr;
            hazard_i <= hazard;
            @(posedge clk);
            @(negedge clk);
            expected = doFlush ? '0 : fieldsOf(instr);
            checkValue(doFlush ? "decode flush" : "decode fields",
                       32'(expected), 32'(decodeInfo_o));
        end
    endtask

    task automatic immediateAlu();
        logic [11:0] imm;
        regAddrT     rd;
        int          i;
        for (i = 0; i < 4; i++) begin
            // Alternate the sign of the immediate
            imm = {1'(i % 2), 11'($urandom())};
            rd  = 5'($urandom_range(1, 31));
            @(posedge clk);
            applyReset();
            instrF_i              <= iTypeInstr(imm, 5'd0, f3AddSub, rd);
            execCtrl_i.immSrc     <= immI;
            execCtrl_i.aluSrc     <= srcBImm;
            execCtrl_i.aluControl <= aluAdd;
            execCtrl_i.forwardA   <= forwardEx;
            execCtrl_i.forwardB   <= forwardEx;
            feedNopsUntilMem(rd, 3, "addi latency");
            checkValue("addi aluResultM", {{20{imm[11]}}, imm}, memAccess_o.aluResultM);
        end
    endtask

    task automatic forwardingSum();
        logic [19:0] upperA;
        logic [19:0] upperB;
        wordT        valA;
        wordT        valB;
        wordT        sum;
        regAddrT     ra;
        regAddrT     rb;
        regAddrT     rc;
        ra     = 5'($urandom_range(1, 9));
        rb     = ra + 5'd10;
        rc     = ra + 5'd20;
        upperA = 20'($urandom());
        upperB = 20'($urandom());
        valA   = {upperA, 12'b0};
        valB   = {upperB, 12'b0};
        sum    = valA + valB;
        @(posedge clk);
        applyReset();
        // Two lui writes with the U immediate as writeback result
        instrF_i                <= luiInstr(upperA, ra);
        execCtrl_i.immSrc       <= immU;
        resultCtrl_i.resultSrcW <= resultImm;
        resultCtrl_i.regWriteW  <= 1'b1;
        @(posedge clk);
        instrF_i <= luiInstr(upperB, rb);
        @(posedge clk);
        instrF_i <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkValue("lui A resultW", valA, writeback_o.resultW);
        checkValue("lui A rdW", 32'(ra), 32'(writeback_o.rdW));
        @(posedge clk);
        @(negedge clk);
        checkValue("lui B resultW", valB, writeback_o.resultW);
        checkValue("lui B rdW", 32'(rb), 32'(writeback_o.rdW));
        // add rc = ra + rb and two adds of rc and x0 right behind it
        @(posedge clk);
        instrF_i                <= rTypeInstr(rb, ra, rc);
        execCtrl_i.immSrc       <= immI;
        execCtrl_i.aluSrc       <= srcBReg;
        execCtrl_i.aluControl   <= aluAdd;
        resultCtrl_i.resultSrcM <= resultAlu;
        resultCtrl_i.resultSrcW <= resultAlu;
        @(posedge clk);
        instrF_i <= rTypeInstr(5'd0, rc, rc + 5'd1);
        @(posedge clk);
        instrF_i <= rTypeInstr(5'd0, rc, rc + 5'd2);
        @(negedge clk);
        checkValue("add rs1E", 32'(ra), 32'(execInfo_o.rs1E));
        checkValue("add rs2E", 32'(rb), 32'(execInfo_o.rs2E));
        checkValue("add rdE", 32'(rc), 32'(execInfo_o.rdE));
        checkValue("add zeroE", 32'(sum == '0), 32'(execInfo_o.zeroE));
        @(posedge clk);
        instrF_i            <= '0;
        execCtrl_i.forwardA <= forwardMem;
        @(negedge clk);
        checkValue("add forwardEx", sum, memAccess_o.aluResultM);
        @(posedge clk);
        execCtrl_i.forwardA <= forwardWb;
        @(negedge clk);
        checkValue("add forwardMem", sum, memAccess_o.aluResultM);
        @(posedge clk);
        execCtrl_i.forwardA <= forwardEx;
        @(negedge clk);
        checkValue("add forwardWb", sum, memAccess_o.aluResultM);
    endtask

    task automatic branchRedirect();
        logic [12:0] imm;
        wordT        target;
        int          i;
        for (i = 0; i < 3; i++) begin
            imm    = {1'(i % 2), 11'($urandom()), 1'b0};
            target = startPc + {{19{imm[12]}}, imm};
            @(posedge clk);
            applyReset();
            // Branch sits at startPc
            instrF_i          <= branchInstr(imm, 5'd0, 5'd0);
            execCtrl_i.immSrc <= immB;
            @(posedge clk);
            instrF_i <= '0;
            @(posedge clk);
            // beq x0, x0 subtracts to zero and is taken
            pcSrcE_i              <= 1'b1;
            execCtrl_i.aluControl <= aluSub;
            @(negedge clk);
            checkValue("branch zeroE", 32'd1, 32'(execInfo_o.zeroE));
            checkValue("branch rdE", 32'({imm[4:1], imm[11]}), 32'(execInfo_o.rdE));
            @(posedge clk);
            pcSrcE_i <= 1'b0;
            @(negedge clk);
            checkValue("branch target", target, pcF_o);
        end
    endtask

    initial begin
        void'($urandom(32'h7902));
        applyReset();
        checkAfterReset();
        fetchAndStall();
        decodeFields();
        immediateAlu();
        forwardingSum();
        branchRedirect();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Guard against a hung run
    initial begin
        #(simLimitNs);
        $display("Timeout: run did not finish within %0d ns, %0d errors so far",
                 simLimitNs, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* pipelineDatapath.f */
design/isaPkg.sv
design/datapathPkg.sv
design/regFile.sv
design/aluUnit.sv
design/fetchDecode.sv
design/executeStage.sv
design/resultStage.sv
design/pipelineDatapath.sv
verification/datapathTb.sv

/* Makefile */
TOP = datapathTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f pipelineDatapath.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -Mdir obj_dir -f pipelineDatapath.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
